// ==== mat_pkg.sv ====
// shared constants and bus types of the uart matrix terminal, imported by every design file
package mat_pkg;

	// ========================================
	// matrix geometry
	// ========================================
	localparam int MAX_DIM   = 5;                  // rows and cols both 1..5
	localparam int MAX_ELEMS = MAX_DIM * MAX_DIM;
	localparam int ELEM_W    = 8;                  // one byte per element
	localparam int DIM_W     = 3;
	localparam int NUM_SLOTS = 2;                  // storage depth
	localparam int SLOT_W    = 1;

	// ========================================
	// uart timing
	// ========================================
	localparam int BAUD_DIV   = 16;                // sim value, board build sets clk / baud
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	// ascii codes used by parser and printer
	localparam logic [7:0] ASCII_ZERO  = 8'h30;
	localparam logic [7:0] ASCII_NINE  = 8'h39;
	localparam logic [7:0] ASCII_SPACE = 8'h20;
	localparam logic [7:0] ASCII_CR    = 8'h0D;
	localparam logic [7:0] ASCII_LF    = 8'h0A;

	// command[1:0] encoding, 3 falls back to idle
	typedef enum logic [1:0] {
		MODE_IDLE    = 2'd0,
		MODE_INPUT   = 2'd1,
		MODE_DISPLAY = 2'd2
	} mode_t;

	// one matrix as it travels between parser, store and printer
	typedef struct packed {
		logic [DIM_W-1:0]            rows;
		logic [DIM_W-1:0]            cols;
		logic [MAX_ELEMS*ELEM_W-1:0] elems;  // row-major with elem 0 in the low byte
	} matrix_t;

	// read request into the store
	typedef struct packed {
		logic              valid;  // single-cycle
		logic [SLOT_W-1:0] slot;
	} rd_req_t;

endpackage

// ==== uart_rx.sv ====
// 8N1 uart receiver, samples the serial line at mid-bit and strobes each received byte
module uart_rx
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       uart_rxd,
	output logic       rx_valid,
	output logic [7:0] rx_data
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t             state;
	logic [1:0]            rxd_sync;  // two-flop synchronizer
	logic                  rxd;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;   // data bit being sampled
	logic [7:0]            shreg;
	logic                  bit_end;
	logic                  half_bit;

	assign rxd      = rxd_sync[1];
	assign bit_end  = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
	assign half_bit = (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1));
	assign rx_data  = shreg;  // stable until the next start bit

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_sync <= 2'b11;  // idle line is high
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shreg    <= '0;
			rx_valid <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], uart_rxd};
			rx_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rxd) begin
						state <= RX_START;  // falling edge
					end
				end
				RX_START: begin
					if (half_bit) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						// still low at mid start bit, else a glitch
						state    <= rxd ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						shreg    <= {rxd, shreg[7:1]};  // lsb first
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				default: begin
					if (bit_end) begin
						state    <= RX_IDLE;
						rx_valid <= rxd;  // framing error drops the byte
					end
				end
			endcase
		end
	end

	// a byte spans ten bit times, strobes never touch
	a_rx_single: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
		else $error("uart_rx strobe longer than one cycle");

endmodule

// ==== uart_tx.sv ====
// 8N1 uart transmitter, sends one byte per tx_en strobe and reports busy while shifting
module uart_tx
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_en,
	input  logic [7:0] tx_data,
	output logic       uart_txd,
	output logic       tx_busy
);

	logic [8:0]            frame;     // data bits then stop bit
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [3:0]            bit_cnt;   // 0 start .. 9 stop

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_txd <= 1'b1;
			tx_busy  <= 1'b0;
			frame    <= '1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (!tx_busy) begin
			if (tx_en) begin
				uart_txd <= 1'b0;  // start bit
				frame    <= {1'b1, tx_data};
				tx_busy  <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end
		end else if (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1)) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;  // stop bit done, line stays high
			end else begin
				uart_txd <= frame[0];
				frame    <= {1'b1, frame[8:1]};
				bit_cnt  <= bit_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// the printer has to respect busy or a byte is lost
	a_tx_no_overrun: assert property (@(posedge clk) disable iff (!rst_n) tx_en |-> !tx_busy)
		else $error("uart_tx strobed while busy");

endmodule

// ==== mode_ctrl.sv ====
// mode register loaded from the command switches on confirm, plus status leds and error flag
module mode_ctrl
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] command,
	input  logic       btn_confirm,
	input  logic       parse_error,
	input  logic       rd_error,
	output mode_t      mode,
	output logic [7:0] led
);

	logic err_flag;  // sticky until the next confirm

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= MODE_IDLE;
			err_flag <= 1'b0;
		end else if (btn_confirm) begin
			err_flag <= 1'b0;
			case (command[1:0])
				2'd1:    mode <= MODE_INPUT;
				2'd2:    mode <= MODE_DISPLAY;
				default: mode <= MODE_IDLE;  // 0 and 3
			endcase
		end else if (parse_error || rd_error) begin
			err_flag <= 1'b1;
		end
	end

	// led[0] input, led[1] display, led[2] error
	assign led = {5'b0, err_flag, mode == MODE_DISPLAY, mode == MODE_INPUT};

endmodule

// ==== uart_parser.sv ====
// byte decoder, builds a matrix frame in input mode and a slot query in display mode
module uart_parser
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mode_t      mode,
	input  logic       rx_valid,
	input  logic [7:0] rx_data,
	output matrix_t    parsed,
	output logic       parse_done,
	output logic       parse_error,
	output rd_req_t    query
);

	typedef enum logic [1:0] {
		PS_ROWS,
		PS_COLS,
		PS_ELEMS
	} ps_state_t;

	ps_state_t                   state;
	mode_t                       mode_q;      // detects a mode change
	logic [DIM_W-1:0]            rows_r;
	logic [DIM_W-1:0]            cols_r;
	logic [MAX_ELEMS*ELEM_W-1:0] elems_r;
	logic [2*DIM_W-1:0]          elem_cnt;
	logic [2*DIM_W-1:0]          elem_total;  // rows x cols
	logic                        byte_in;
	logic                        is_digit;
	logic                        is_dim;
	logic                        is_slot;
	logic                        elem_last;
	logic                        elem_wr;

	// ========================================
	// byte classification
	// ========================================
	assign byte_in    = rx_valid && (rx_data != ASCII_SPACE) && (mode == mode_q);  // spaces skipped
	assign is_digit   = (rx_data >= ASCII_ZERO) && (rx_data <= ASCII_NINE);
	assign is_dim     = (rx_data > ASCII_ZERO) && (rx_data <= ASCII_ZERO + 8'(MAX_DIM));
	assign is_slot    = (rx_data >= ASCII_ZERO) && (rx_data < ASCII_ZERO + 8'(NUM_SLOTS));
	assign elem_total = rows_r * cols_r;
	assign elem_last  = (elem_cnt == elem_total - 1'b1);
	assign elem_wr    = byte_in && (mode == MODE_INPUT) && (state == PS_ELEMS) && is_digit;

	assign parsed = '{rows: rows_r, cols: cols_r, elems: elems_r};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= PS_ROWS;
			mode_q      <= MODE_IDLE;
			rows_r      <= '0;
			cols_r      <= '0;
			elem_cnt    <= '0;
			parse_done  <= 1'b0;
			parse_error <= 1'b0;
			query       <= '0;
		end else begin
			mode_q      <= mode;
			parse_done  <= 1'b0;
			parse_error <= 1'b0;
			query.valid <= 1'b0;
			if (mode != mode_q) begin
				state <= PS_ROWS;  // fresh frame on every mode change
			end else if (byte_in && mode == MODE_INPUT) begin
				case (state)
					PS_ROWS: begin
						if (is_dim) begin
							rows_r <= rx_data[DIM_W-1:0];  // '1'..'5' low bits give the value
							state  <= PS_COLS;
						end else begin
							parse_error <= 1'b1;
						end
					end
					PS_COLS: begin
						if (is_dim) begin
							cols_r   <= rx_data[DIM_W-1:0];
							elem_cnt <= '0;
							state    <= PS_ELEMS;
						end else begin
							parse_error <= 1'b1;
							state       <= PS_ROWS;
						end
					end
					default: begin
						if (!is_digit) begin
							parse_error <= 1'b1;
							state       <= PS_ROWS;
						end else if (elem_last) begin
							parse_done <= 1'b1;  // frame complete
							state      <= PS_ROWS;
						end else begin
							elem_cnt <= elem_cnt + 1'b1;
						end
					end
				endcase
			end else if (byte_in && mode == MODE_DISPLAY) begin
				if (is_slot) begin
					query.valid <= 1'b1;
					query.slot  <= rx_data[SLOT_W-1:0];  // '0' or '1'
				end else begin
					parse_error <= 1'b1;
				end
			end
		end
	end

	// element payload
	always_ff @(posedge clk) begin
		if (elem_wr) begin
			elems_r[elem_cnt*ELEM_W +: ELEM_W] <= rx_data - ASCII_ZERO;
		end
	end

	a_done_or_error: assert property (@(posedge clk) disable iff (!rst_n)
		!(parse_done && parse_error))
		else $error("parser reported done and error together");

endmodule

// ==== matrix_store.sv ====
// two-slot matrix memory, round-robin writes and one-cycle indexed reads with empty-slot error
module matrix_store
	import mat_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    wr_en,
	input  matrix_t wr_matrix,
	input  rd_req_t query,
	output matrix_t rd_matrix,
	output logic    rd_done,
	output logic    rd_error
);

	matrix_t              mem [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] slot_valid;  // slot has been written
	logic [SLOT_W-1:0]    wr_ptr;      // next slot to overwrite

	// ========================================
	// control
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= '0;
			wr_ptr     <= '0;
			rd_done    <= 1'b0;
			rd_error   <= 1'b0;
		end else begin
			rd_done  <= 1'b0;
			rd_error <= 1'b0;
			if (wr_en) begin
				slot_valid[wr_ptr] <= 1'b1;
				wr_ptr             <= wr_ptr + 1'b1;  // toggles between the two slots
			end
			// valid sampled before this cycle's write
			if (query.valid) begin
				if (slot_valid[query.slot]) begin
					rd_done <= 1'b1;
				end else begin
					rd_error <= 1'b1;  // empty slot
				end
			end
		end
	end

	// ========================================
	// storage
	// ========================================
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_matrix;
		end
		if (query.valid) begin
			rd_matrix <= mem[query.slot];  // old contents on a same-cycle write
		end
	end

endmodule

// ==== matrix_printer.sv ====
// prints a matrix as ascii digits with spaces and crlf, one byte per free transmitter slot
module matrix_printer
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  matrix_t    matrix,
	input  logic       tx_busy,
	output logic       tx_en,
	output logic [7:0] tx_data,
	output logic       done
);

	typedef enum logic [2:0] {
		PR_IDLE,
		PR_ELEM,
		PR_SPACE,
		PR_CR,
		PR_LF
	} pr_state_t;

	pr_state_t          state;
	matrix_t            mat_r;     // copy taken on start
	logic [DIM_W-1:0]   row_r;
	logic [DIM_W-1:0]   col_r;
	logic [2*DIM_W-1:0] elem_idx;  // row-major walk
	logic               send;
	logic [7:0]         next_byte;

	// tx_busy only rises the cycle after tx_en, so skip that cycle too
	assign send = (state != PR_IDLE) && !tx_busy && !tx_en;

	always_comb begin
		case (state)
			PR_ELEM:  next_byte = mat_r.elems[elem_idx*ELEM_W +: ELEM_W] + ASCII_ZERO;
			PR_SPACE: next_byte = ASCII_SPACE;
			PR_CR:    next_byte = ASCII_CR;
			default:  next_byte = ASCII_LF;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= PR_IDLE;
			row_r    <= '0;
			col_r    <= '0;
			elem_idx <= '0;
			tx_en    <= 1'b0;
			done     <= 1'b0;
		end else begin
			tx_en <= send;
			done  <= 1'b0;
			case (state)
				PR_IDLE: begin
					if (start) begin
						state    <= PR_ELEM;
						row_r    <= '0;
						col_r    <= '0;
						elem_idx <= '0;
					end
				end
				PR_ELEM: begin
					if (send) begin
						elem_idx <= elem_idx + 1'b1;
						// last column goes straight to crlf
						state    <= (col_r == mat_r.cols - 1'b1) ? PR_CR : PR_SPACE;
					end
				end
				PR_SPACE: begin
					if (send) begin
						col_r <= col_r + 1'b1;
						state <= PR_ELEM;
					end
				end
				PR_CR: begin
					if (send) begin
						state <= PR_LF;
					end
				end
				default: begin
					if (send) begin
						col_r <= '0;
						if (row_r == mat_r.rows - 1'b1) begin
							state <= PR_IDLE;
							done  <= 1'b1;  // with the final lf strobe
						end else begin
							row_r <= row_r + 1'b1;
							state <= PR_ELEM;
						end
					end
				end
			endcase
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (start && state == PR_IDLE) begin
			mat_r <= matrix;
		end
		if (send) begin
			tx_data <= next_byte;
		end
	end

	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> state == PR_IDLE)
		else $error("print start dropped while printer busy");

endmodule

// ==== matrix_sys_top.sv ====
// top of the uart matrix terminal, connects receiver, parser, store, printer and transmitter
module matrix_sys_top
	import mat_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] command,
	input  logic       btn_confirm,
	input  logic       uart_rxd,
	output logic       uart_txd,
	output logic [7:0] led
);

	logic       rx_valid;
	logic [7:0] rx_data;
	logic       tx_en;
	logic [7:0] tx_data;
	logic       tx_busy;
	mode_t      mode;
	matrix_t    parsed;
	logic       parse_done;
	logic       parse_error;
	rd_req_t    query;
	matrix_t    rd_matrix;
	logic       rd_done;
	logic       rd_error;
	logic       print_start;
	matrix_t    print_matrix;

	// echo of a fresh frame or a stored slot
	assign print_start  = parse_done | rd_done;
	assign print_matrix = parse_done ? parsed : rd_matrix;

	// ========================================
	// serial side
	// ========================================
	uart_rx uart_rx_inst (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd), .rx_valid(rx_valid), .rx_data(rx_data)
	);

	uart_tx uart_tx_inst (
		.clk(clk), .rst_n(rst_n), .tx_en(tx_en), .tx_data(tx_data),
		.uart_txd(uart_txd), .tx_busy(tx_busy)
	);

	mode_ctrl mode_ctrl_inst (
		.clk(clk), .rst_n(rst_n), .command(command), .btn_confirm(btn_confirm),
		.parse_error(parse_error), .rd_error(rd_error), .mode(mode), .led(led)
	);

	// ========================================
	// matrix path
	// ========================================
	uart_parser uart_parser_inst (
		.clk(clk), .rst_n(rst_n), .mode(mode), .rx_valid(rx_valid), .rx_data(rx_data),
		.parsed(parsed), .parse_done(parse_done), .parse_error(parse_error), .query(query)
	);

	matrix_store matrix_store_inst (
		.clk(clk), .rst_n(rst_n), .wr_en(parse_done), .wr_matrix(parsed), .query(query),
		.rd_matrix(rd_matrix), .rd_done(rd_done), .rd_error(rd_error)
	);

	// completion pulse not needed at this level
	matrix_printer matrix_printer_inst (
		.clk(clk), .rst_n(rst_n), .start(print_start), .matrix(print_matrix),
		.tx_busy(tx_busy), .tx_en(tx_en), .tx_data(tx_data), .done()
	);

endmodule

// ==== tb_matrix_sys.sv ====
// self-checking testbench for the uart matrix terminal, run with all.f and tb_matrix_sys as top
module tb_matrix_sys
	import mat_pkg::*;
;

	localparam int NUM_ROWS  = 12;
	localparam int IDLE_BITS = 20;  // line quiet this long ends a row

	logic       clk;
	logic       rst_n;
	logic [7:0] command;
	logic       btn_confirm;
	logic       uart_rxd;
	logic       uart_txd;
	logic [7:0] led;

	logic [7:0] got_q [$];   // bytes seen on uart_txd
	logic       rx_active;   // monitor inside a frame
	int         cycle_cnt = 0;
	int         timeout_cycles = 0;

	// ========================================
	// stimulus table
	// ========================================
	// crlf written as octal \015\012
	logic [7:0] cmd_tab [NUM_ROWS] = '{8'h02, 8'h01, 8'h01, 8'h02, 8'h02, 8'h01,
		8'h02, 8'h02, 8'h01, 8'h01, 8'h01, 8'h00};
	string in_tab [NUM_ROWS] = '{
		"0",                    // empty slot right after reset
		"2 3 1 2 3 4 5 6",
		"1 1 7",
		"0",
		"1",
		"2 2 9 8 7 6",          // overwrites slot 0
		"0",
		"1",
		"2 2 1 x",              // letter inside a frame
		"6",                    // row count out of range
		"1 q 2 1 3 8",          // bad byte then a good frame
		""
	};
	string out_tab [NUM_ROWS] = '{
		"",
		"1 2 3\015\0124 5 6\015\012",
		"7\015\012",
		"1 2 3\015\0124 5 6\015\012",
		"7\015\012",
		"9 8\015\0127 6\015\012",
		"9 8\015\0127 6\015\012",
		"7\015\012",
		"",
		"",
		"3\015\0128\015\012",
		""
	};
	logic [7:0] led_tab [NUM_ROWS] = '{8'h06, 8'h01, 8'h01, 8'h02, 8'h02, 8'h01,
		8'h02, 8'h02, 8'h05, 8'h05, 8'h05, 8'h00};

	matrix_sys_top matrix_sys_top_inst (
		.clk(clk), .rst_n(rst_n), .command(command), .btn_confirm(btn_confirm),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd), .led(led)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ========================================
	// helpers
	// ========================================
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	function automatic int run_limit();
		int total;
		int r;
		total = 1000;
		for (r = 0; r < NUM_ROWS; r++) begin
			total += 12 * BAUD_DIV * (in_tab[r].len() + out_tab[r].len() + IDLE_BITS);
		end
		return total;
	endfunction

	// one 8n1 frame on uart_rxd, called on a falling edge
	task automatic send_byte(input logic [7:0] b);
		int i;
		uart_rxd = 1'b0;  // start
		repeat (BAUD_DIV) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			uart_rxd = b[i];  // lsb first
			repeat (BAUD_DIV) @(negedge clk);
		end
		uart_rxd = 1'b1;  // stop
		repeat (BAUD_DIV) @(negedge clk);
	endtask

	task automatic send_string(input string s);
		int k;
		for (k = 0; k < s.len(); k++) begin
			send_byte(s[k]);
		end
	endtask

	task automatic confirm_mode(input logic [7:0] cmd);
		command     = cmd;
		btn_confirm = 1'b1;
		@(negedge clk);
		btn_confirm = 1'b0;
		repeat (2) @(negedge clk);  // mode and leds settle
	endtask

	// returns once both lines have been quiet for IDLE_BITS bit times
	task automatic wait_line_idle();
		int idle;
		idle = 0;
		while (idle < IDLE_BITS * BAUD_DIV) begin
			@(negedge clk);
			if (uart_txd && !rx_active) begin
				idle++;
			end else begin
				idle = 0;
			end
		end
	endtask

	task automatic check_row(input int r);
		int i;
		assert (got_q.size() == out_tab[r].len())
			else abort_run($sformatf("FAILED row %0d uart_txd byte count expected %h got %h",
				r, out_tab[r].len(), got_q.size()));
		for (i = 0; i < got_q.size(); i++) begin
			assert (got_q[i] == out_tab[r][i])
				else abort_run($sformatf("FAILED row %0d uart_txd byte %0d expected %h got %h",
					r, i, out_tab[r][i], got_q[i]));
		end
		assert (led == led_tab[r])
			else abort_run($sformatf("FAILED row %0d led expected %h got %h",
				r, led_tab[r], led));
		got_q.delete();
	endtask

	// ========================================
	// uart_txd monitor
	// ========================================
	initial begin : tx_monitor
		logic [7:0] rx_byte;
		int         i;
		rx_active = 1'b0;
		forever begin
			@(negedge clk);
			if (rst_n && !uart_txd) begin
				rx_active = 1'b1;
				repeat (BAUD_DIV / 2 - 1) @(negedge clk);  // mid start bit
				assert (!uart_txd) else abort_run("start bit on uart_txd ended before mid-bit");
				for (i = 0; i < 8; i++) begin
					repeat (BAUD_DIV) @(negedge clk);
					rx_byte[i] = uart_txd;
				end
				repeat (BAUD_DIV) @(negedge clk);
				assert (uart_txd) else abort_run("stop bit missing on uart_txd");
				got_q.push_back(rx_byte);
				rx_active = 1'b0;
			end
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_cycles > 0 && cycle_cnt >= timeout_cycles) begin
			abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
		end
	end

	// ========================================
	// main sequence
	// ========================================
	initial begin : main_seq
		int r;
		rst_n          = 1'b0;
		command        = 8'h00;
		btn_confirm    = 1'b0;
		uart_rxd       = 1'b1;  // idle line
		timeout_cycles = run_limit();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);

		// reset state
		assert (uart_txd === 1'b1)
			else abort_run($sformatf("FAILED uart_txd after reset expected %h got %h",
				1'b1, uart_txd));
		assert (led === 8'h00)
			else abort_run($sformatf("FAILED led after reset expected %h got %h", 8'h00, led));
		wait_line_idle();
		assert (got_q.size() == 0)
			else abort_run($sformatf("FAILED uart_txd byte count before stimulus expected %h got %h",
				0, got_q.size()));

		for (r = 0; r < NUM_ROWS; r++) begin
			confirm_mode(cmd_tab[r]);  // also clears the error led
			send_string(in_tab[r]);
			wait_line_idle();
			check_row(r);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== all.f ====
mat_pkg.sv
uart_rx.sv
uart_tx.sv
mode_ctrl.sv
uart_parser.sv
matrix_store.sv
matrix_printer.sv
matrix_sys_top.sv
tb_matrix_sys.sv
